// ==== rtl/cl_host_macros.svh ====
//----------------------------------------------------------
// Host control block constants
//----------------------------------------------------------
`ifndef CL_HOST_MACROS_SVH
`define CL_HOST_MACROS_SVH

// Word and link field widths
`define CL_DATA_W          32
`define CL_X_CORD_W        4
`define CL_Y_CORD_W        4
`define CL_EPA_W           20
`define CL_REG_IDX_W       4
`define CL_VIO_W           16

// Link flow control
`define CL_MAX_OUT_CREDITS 4
`define CL_CREDIT_W        3

// Identity words
`define CL_SH_ID0          32'hF000_1D0F
`define CL_SH_ID1          32'h1D51_FEDD

// Local register map
`define CL_REG_ID0         4'd0
`define CL_REG_ID1         4'd1
`define CL_REG_VDIP        4'd2
`define CL_REG_VLED        4'd3
`define CL_REG_CREDITS     4'd4

`endif

// ==== rtl/cl_host_pkg.sv ====
//----------------------------------------------------------
// Host control block types
//----------------------------------------------------------
`default_nettype none

`include "cl_host_macros.svh"

package cl_host_pkg;

  // AXI style response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef logic [`CL_CREDIT_W-1:0] credit_t;

  typedef struct packed {
    logic                   write;
    logic [`CL_DATA_W-1:0]  addr;
    logic [`CL_DATA_W-1:0]  data;
    logic [3:0]             strb;
  } host_req_t;

  typedef struct packed {
    logic [`CL_DATA_W-1:0]  data;
    logic [1:0]             resp;
  } host_rsp_t;

  //----------------------------------------------------------
  // Host address word, register view and link view
  //----------------------------------------------------------
  typedef struct packed {
    logic                                 remote;
    logic [`CL_DATA_W-2-`CL_REG_IDX_W:0]  rsvd;
    logic [`CL_REG_IDX_W-1:0]             reg_idx;
  } host_addr_local_t;

  typedef struct packed {
    logic                                                         remote;
    logic [`CL_DATA_W-2-`CL_Y_CORD_W-`CL_X_CORD_W-`CL_EPA_W:0]    rsvd;
    logic [`CL_Y_CORD_W-1:0]                                      y;
    logic [`CL_X_CORD_W-1:0]                                      x;
    logic [`CL_EPA_W-1:0]                                         epa;
  } host_addr_remote_t;

  typedef union packed {
    host_addr_local_t   lcl;
    host_addr_remote_t  rmt;
  } host_addr_u;

  typedef struct packed {
    logic                     store;
    logic [`CL_X_CORD_W-1:0]  x;
    logic [`CL_Y_CORD_W-1:0]  y;
    logic [`CL_EPA_W-1:0]     epa;
    logic [`CL_DATA_W-1:0]    data;
    logic [3:0]               mask;
  } link_req_t;

  // Stores come back with zero data
  typedef struct packed {
    logic [`CL_DATA_W-1:0]    data;
  } link_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/cl_host_top.sv ====
//----------------------------------------------------------
// Host control block top
//----------------------------------------------------------
`default_nettype none

`include "cl_host_macros.svh"

module cl_host_top
  import cl_host_pkg::*;
(
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n_sync,

  input  host_req_t             host_req_i,
  input  logic                  host_req_valid_i,
  output logic                  host_req_ready_o,

  output host_rsp_t             host_rsp_o,
  output logic                  host_rsp_valid_o,
  input  logic                  host_rsp_ready_i,

  output link_req_t             link_req_o,
  output logic                  link_req_valid_o,
  input  logic                  link_req_ready_i,

  input  link_rsp_t             link_rsp_i,
  input  logic                  link_rsp_valid_i,

  input  logic [`CL_VIO_W-1:0]  sh_cl_status_vdip_i,
  output logic [`CL_VIO_W-1:0]  cl_sh_status_vled_o
);

  host_req_t  remote_req;
  logic       remote_valid;
  logic       remote_ready;
  host_req_t  local_req;
  logic       local_valid;
  host_rsp_t  local_rsp;
  logic       local_rsp_valid;
  credit_t    outstanding;
  credit_t    credits;
  logic       credit_return;
  logic       resp_empty;

  //----------------------------------------------------------
  // Decode
  //----------------------------------------------------------
  host_req_decode host_req_decode_inst (
    .clk_main_a0      (clk_main_a0),
    .rst_main_n_sync  (rst_main_n_sync),
    .host_req_i       (host_req_i),
    .host_req_valid_i (host_req_valid_i),
    .host_req_ready_o (host_req_ready_o),
    .remote_req_o     (remote_req),
    .remote_valid_o   (remote_valid),
    .remote_ready_i   (remote_ready),
    .local_req_o      (local_req),
    .local_valid_o    (local_valid),
    .outstanding_i    (outstanding),
    .resp_empty_i     (resp_empty)
  );

  //----------------------------------------------------------
  // Execute
  //----------------------------------------------------------
  status_regs status_regs_inst (
    .clk_main_a0         (clk_main_a0),
    .rst_main_n_sync     (rst_main_n_sync),
    .local_req_i         (local_req),
    .local_valid_i       (local_valid),
    .credits_i           (credits),
    .sh_cl_status_vdip_i (sh_cl_status_vdip_i),
    .cl_sh_status_vled_o (cl_sh_status_vled_o),
    .local_rsp_o         (local_rsp),
    .local_rsp_valid_o   (local_rsp_valid)
  );

  link_req_issue link_req_issue_inst (
    .clk_main_a0      (clk_main_a0),
    .rst_main_n_sync  (rst_main_n_sync),
    .remote_req_i     (remote_req),
    .remote_valid_i   (remote_valid),
    .remote_ready_o   (remote_ready),
    .link_req_o       (link_req_o),
    .link_req_valid_o (link_req_valid_o),
    .link_req_ready_i (link_req_ready_i),
    .credit_return_i  (credit_return),
    .outstanding_o    (outstanding),
    .credits_o        (credits)
  );

  //----------------------------------------------------------
  // Result
  //----------------------------------------------------------
  host_resp_return host_resp_return_inst (
    .clk_main_a0       (clk_main_a0),
    .rst_main_n_sync   (rst_main_n_sync),
    .local_rsp_i       (local_rsp),
    .local_rsp_valid_i (local_rsp_valid),
    .link_rsp_i        (link_rsp_i),
    .link_rsp_valid_i  (link_rsp_valid_i),
    .host_rsp_o        (host_rsp_o),
    .host_rsp_valid_o  (host_rsp_valid_o),
    .host_rsp_ready_i  (host_rsp_ready_i),
    .credit_return_o   (credit_return),
    .resp_empty_o      (resp_empty)
  );

endmodule

`default_nettype wire

// ==== rtl/host_req_decode.sv ====
//----------------------------------------------------------
// Host request decode
//----------------------------------------------------------
`default_nettype none

module host_req_decode
  import cl_host_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,

  input  host_req_t  host_req_i,
  input  logic       host_req_valid_i,
  output logic       host_req_ready_o,

  output host_req_t  remote_req_o,
  output logic       remote_valid_o,
  input  logic       remote_ready_i,

  output host_req_t  local_req_o,
  output logic       local_valid_o,

  input  credit_t    outstanding_i,
  input  logic       resp_empty_i
);

  host_addr_u  addr_view;
  logic        is_remote;
  logic        local_ok;

  assign addr_view = host_req_i.addr;
  assign is_remote = addr_view.rmt.remote;

  // Local answers are immediate, so wait until every older
  // link access has drained out of the response stage
  assign local_ok = (outstanding_i == '0) && resp_empty_i;

  //----------------------------------------------------------
  // Routing
  //----------------------------------------------------------
  assign remote_req_o   = host_req_i;
  assign remote_valid_o = host_req_valid_i && is_remote;

  assign local_req_o    = host_req_i;
  // One cycle strobe on acceptance
  assign local_valid_o  = host_req_valid_i && !is_remote && local_ok;

  assign host_req_ready_o = is_remote ? remote_ready_i : local_ok;

  // Exactly one destination per host request
  a_one_destination : assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    !(local_valid_o && remote_valid_o)
  );

endmodule

`default_nettype wire

// ==== rtl/host_resp_return.sv ====
//----------------------------------------------------------
// Host response return
//----------------------------------------------------------
`default_nettype none

`include "cl_host_macros.svh"

module host_resp_return
  import cl_host_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,

  input  host_rsp_t  local_rsp_i,
  input  logic       local_rsp_valid_i,

  input  link_rsp_t  link_rsp_i,
  input  logic       link_rsp_valid_i,

  output host_rsp_t  host_rsp_o,
  output logic       host_rsp_valid_o,
  input  logic       host_rsp_ready_i,

  output logic       credit_return_o,
  output logic       resp_empty_o
);

  // Depth is a power of two so the pointers wrap on their own
  localparam int DEPTH = `CL_MAX_OUT_CREDITS;
  localparam int PTR_W = $clog2(DEPTH);

  link_rsp_t         fifo_mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  credit_t           count_q;
  host_rsp_t         loc_rsp_q;
  logic              loc_valid_q;
  logic              fifo_empty;
  logic              fifo_full;
  logic              fifo_push;
  logic              fifo_pop;
  logic              loc_pop;

  assign fifo_empty = (count_q == '0);
  assign fifo_full  = (count_q == credit_t'(DEPTH));
  assign fifo_push  = link_rsp_valid_i;

  // A held local answer is always older than anything queued behind it
  assign loc_pop  = loc_valid_q && host_rsp_ready_i;
  assign fifo_pop = !loc_valid_q && !fifo_empty && host_rsp_ready_i;

  //----------------------------------------------------------
  // Link response FIFO
  //----------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (fifo_push) begin
      fifo_mem[wr_ptr_q] <= link_rsp_i;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (fifo_push) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      end
      if (fifo_pop) begin
        rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      end
      case ({fifo_push, fifo_pop})
        2'b10:   count_q <= count_q + credit_t'(1);
        2'b01:   count_q <= count_q - credit_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  //----------------------------------------------------------
  // Local response holding register
  //----------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (local_rsp_valid_i) begin
      loc_rsp_q <= local_rsp_i;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      loc_valid_q <= 1'b0;
    end else if (local_rsp_valid_i) begin
      loc_valid_q <= 1'b1;
    end else if (loc_pop) begin
      loc_valid_q <= 1'b0;
    end
  end

  always_comb begin
    if (loc_valid_q) begin
      host_rsp_o = loc_rsp_q;
    end else begin
      host_rsp_o.data = fifo_mem[rd_ptr_q].data;
      host_rsp_o.resp = RESP_OKAY;
    end
  end

  assign host_rsp_valid_o = loc_valid_q || !fifo_empty;
  assign credit_return_o  = fifo_pop;
  assign resp_empty_o     = !loc_valid_q && fifo_empty;

  // Credit limit upstream keeps room for every link response
  a_fifo_no_overflow : assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    fifo_push |-> !fifo_full
  );

  // Decode never lets a second local access in behind a held one
  a_local_single : assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    local_rsp_valid_i |-> !loc_valid_q
  );

endmodule

`default_nettype wire

// ==== rtl/link_req_issue.sv ====
//----------------------------------------------------------
// Link request issue
//----------------------------------------------------------
`default_nettype none

`include "cl_host_macros.svh"

module link_req_issue
  import cl_host_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,

  input  host_req_t  remote_req_i,
  input  logic       remote_valid_i,
  output logic       remote_ready_o,

  output link_req_t  link_req_o,
  output logic       link_req_valid_o,
  input  logic       link_req_ready_i,

  input  logic       credit_return_i,
  output credit_t    outstanding_o,
  output credit_t    credits_o
);

  localparam credit_t MAX_CREDITS = credit_t'(`CL_MAX_OUT_CREDITS);

  host_addr_u  addr_view;
  link_req_t   link_req_q;
  logic        link_valid_q;
  credit_t     outstanding_q;
  logic        accept;

  assign addr_view = remote_req_i.addr;

  // Output slot must be free or draining, and a credit must be left
  assign remote_ready_o = (outstanding_q < MAX_CREDITS) && (!link_valid_q || link_req_ready_i);
  assign accept         = remote_valid_i && remote_ready_o;

  //----------------------------------------------------------
  // Packet register
  //----------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (accept) begin
      link_req_q.store <= remote_req_i.write;
      link_req_q.x     <= addr_view.rmt.x;
      link_req_q.y     <= addr_view.rmt.y;
      link_req_q.epa   <= addr_view.rmt.epa;
      link_req_q.data  <= remote_req_i.data;
      link_req_q.mask  <= remote_req_i.strb;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      link_valid_q <= 1'b0;
    end else if (accept) begin
      link_valid_q <= 1'b1;
    end else if (link_req_ready_i) begin
      link_valid_q <= 1'b0;
    end
  end

  //----------------------------------------------------------
  // Outstanding credit counter
  //----------------------------------------------------------
  // Counted from acceptance so a packet still waiting here holds a credit
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      outstanding_q <= '0;
    end else begin
      case ({accept, credit_return_i})
        2'b10:   outstanding_q <= outstanding_q + credit_t'(1);
        2'b01:   outstanding_q <= outstanding_q - credit_t'(1);
        default: outstanding_q <= outstanding_q;
      endcase
    end
  end

  assign link_req_o       = link_req_q;
  assign link_req_valid_o = link_valid_q;
  assign outstanding_o    = outstanding_q;
  assign credits_o        = MAX_CREDITS - outstanding_q;

  a_credit_limit : assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    outstanding_q <= MAX_CREDITS
  );

  // Response stage only frees credits that were taken
  a_no_spurious_return : assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    credit_return_i |-> (outstanding_q != '0)
  );

endmodule

`default_nettype wire

// ==== rtl/status_regs.sv ====
//----------------------------------------------------------
// Status register bank
//----------------------------------------------------------
`default_nettype none

`include "cl_host_macros.svh"

module status_regs
  import cl_host_pkg::*;
(
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n_sync,

  input  host_req_t             local_req_i,
  input  logic                  local_valid_i,

  input  credit_t               credits_i,

  input  logic [`CL_VIO_W-1:0]  sh_cl_status_vdip_i,
  output logic [`CL_VIO_W-1:0]  cl_sh_status_vled_o,

  output host_rsp_t             local_rsp_o,
  output logic                  local_rsp_valid_o
);

  host_addr_u                 addr_view;
  logic [`CL_REG_IDX_W-1:0]   reg_idx;
  logic [`CL_VIO_W-1:0]       vdip_q;
  logic [`CL_VIO_W-1:0]       vdip_q2;
  logic [`CL_VIO_W-1:0]       vled_q;
  logic                       led_wr;

  assign addr_view = local_req_i.addr;
  assign reg_idx   = addr_view.lcl.reg_idx;
  assign led_wr    = local_valid_i && local_req_i.write && (reg_idx == `CL_REG_VLED);

  //----------------------------------------------------------
  // DIP synchronizer and LED register
  //----------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q  <= '0;
      vdip_q2 <= '0;
      vled_q  <= '0;
    end else begin
      vdip_q  <= sh_cl_status_vdip_i;
      vdip_q2 <= vdip_q;
      // Only the low two byte lanes map onto the LEDs
      if (led_wr) begin
        if (local_req_i.strb[0]) begin
          vled_q[7:0] <= local_req_i.data[7:0];
        end
        if (local_req_i.strb[1]) begin
          vled_q[15:8] <= local_req_i.data[15:8];
        end
      end
    end
  end

  assign cl_sh_status_vled_o = vled_q;

  //----------------------------------------------------------
  // Read mux and response code
  //----------------------------------------------------------
  always_comb begin
    local_rsp_o.data = '0;
    local_rsp_o.resp = RESP_SLVERR;
    if (local_req_i.write) begin
      if (reg_idx == `CL_REG_VLED) begin
        local_rsp_o.resp = RESP_OKAY;
      end
    end else begin
      local_rsp_o.resp = RESP_OKAY;
      case (reg_idx)
        `CL_REG_ID0:     local_rsp_o.data = `CL_SH_ID0;
        `CL_REG_ID1:     local_rsp_o.data = `CL_SH_ID1;
        `CL_REG_VDIP:    local_rsp_o.data = `CL_DATA_W'(vdip_q2);
        `CL_REG_VLED:    local_rsp_o.data = `CL_DATA_W'(vled_q);
        `CL_REG_CREDITS: local_rsp_o.data = `CL_DATA_W'(credits_i);
        default:         local_rsp_o.resp = RESP_SLVERR;
      endcase
    end
  end

  // Captured by the response stage on this edge
  assign local_rsp_valid_o = local_valid_i;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the host control block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_cl_host \
  --Mdir obj_dir -o sim_cl_host \
  -f src.f

./obj_dir/sim_cl_host | tee sim.log

if grep -qx "Test passed" sim.log; then
  echo "Simulation passed, see sim.log"
else
  echo "Simulation did not pass, see sim.log"
  exit 1
fi

// ==== src.f ====
+incdir+rtl
rtl/cl_host_pkg.sv
rtl/host_req_decode.sv
rtl/status_regs.sv
rtl/link_req_issue.sv
rtl/host_resp_return.sv
rtl/cl_host_top.sv
test/tb_link_model.sv
test/tb_cl_host.sv

// ==== test/cl_host_cases.txt ====
# op addr data strb exp_data exp_resp, all hex
# op 0 read, 1 write, 2 set DIP to data, 3 drain, 4 random response ready from data bit 0
0 00000000 00000000 0 F0001D0F 0
0 00000001 00000000 0 1D51FEDD 0
1 00000003 DEADA5C3 f 00000000 0
0 00000003 00000000 0 0000A5C3 0
1 00000003 12345678 1 00000000 0
0 00000003 00000000 0 0000A578 0
1 00000000 11111111 f 00000000 2
1 00000004 22222222 f 00000000 2
0 00000007 00000000 0 00000000 2
2 00000000 00005AF0 0 00000000 0
0 00000002 00000000 0 00005AF0 0
1 81200010 CAFE0001 f 00000000 0
1 81200014 CAFE0002 f 00000000 0
1 8340ABC0 BEEF0003 f 00000000 0
1 8F5FFFFC 01234567 f 00000000 0
1 81200018 55AA55AA 3 00000000 0
0 81200010 00000000 0 CAFE0001 0
0 81200014 00000000 0 CAFE0002 0
0 8340ABC0 00000000 0 BEEF0003 0
0 8F5FFFFC 00000000 0 01234567 0
0 81200018 00000000 0 000055AA 0
0 81200020 00000000 0 00000000 0
4 00000000 00000001 0 00000000 0
1 82300100 A5A5A5A5 f 00000000 0
1 82300104 5A5A5A5A f 00000000 0
1 82300108 0F0F0F0F c 00000000 0
0 82300100 00000000 0 A5A5A5A5 0
0 82300104 00000000 0 5A5A5A5A 0
0 82300108 00000000 0 0F0F0000 0
0 81200010 00000000 0 CAFE0001 0
0 00000003 00000000 0 0000A578 0
4 00000000 00000000 0 00000000 0
3 00000000 00000000 0 00000000 0
0 00000004 00000000 0 00000004 0

// ==== test/tb_cl_host.sv ====
//----------------------------------------------------------
// Host control block testbench
//----------------------------------------------------------
`default_nettype none

`include "cl_host_macros.svh"

module tb_cl_host
  import cl_host_pkg::*;
();

  localparam int CLK_PERIOD      = 100;
  localparam int SKEW            = 10;
  localparam int RST_CYCLES      = 8;
  localparam int CYCLES_PER_CASE = 200;
  localparam int SEED            = 46;

  // Case file operation codes
  localparam logic [3:0] OP_READ  = 4'h0;
  localparam logic [3:0] OP_WRITE = 4'h1;
  localparam logic [3:0] OP_DIP   = 4'h2;
  localparam logic [3:0] OP_DRAIN = 4'h3;
  localparam logic [3:0] OP_BP    = 4'h4;

  typedef struct packed {
    logic [3:0]   op;
    logic [31:0]  addr;
    logic [31:0]  data;
    logic [3:0]   strb;
    logic [31:0]  exp_data;
    logic [1:0]   exp_resp;
  } case_t;

  typedef struct packed {
    logic [31:0]  addr;
    logic [31:0]  data;
    logic [1:0]   resp;
    logic         led_read;
  } expect_t;

  logic                  clk_main_a0;
  logic                  rst_main_n_sync;
  host_req_t             host_req_i;
  logic                  host_req_valid_i;
  logic                  host_req_ready_o;
  host_rsp_t             host_rsp_o;
  logic                  host_rsp_valid_o;
  logic                  host_rsp_ready_i;
  link_req_t             link_req_o;
  logic                  link_req_valid_o;
  logic                  link_req_ready_i;
  link_rsp_t             link_rsp_i;
  logic                  link_rsp_valid_i;
  logic [`CL_VIO_W-1:0]  sh_cl_status_vdip_i;
  logic [`CL_VIO_W-1:0]  cl_sh_status_vled_o;

  case_t        cases [$];
  expect_t      exp_q [$];
  logic         bp_mode;
  int unsigned  cycle_cnt = 0;
  int unsigned  cycle_limit = 100000;
  int           link_unanswered = 0;

  cl_host_top cl_host_top_inst (
    .clk_main_a0         (clk_main_a0),
    .rst_main_n_sync     (rst_main_n_sync),
    .host_req_i          (host_req_i),
    .host_req_valid_i    (host_req_valid_i),
    .host_req_ready_o    (host_req_ready_o),
    .host_rsp_o          (host_rsp_o),
    .host_rsp_valid_o    (host_rsp_valid_o),
    .host_rsp_ready_i    (host_rsp_ready_i),
    .link_req_o          (link_req_o),
    .link_req_valid_o    (link_req_valid_o),
    .link_req_ready_i    (link_req_ready_i),
    .link_rsp_i          (link_rsp_i),
    .link_rsp_valid_i    (link_rsp_valid_i),
    .sh_cl_status_vdip_i (sh_cl_status_vdip_i),
    .cl_sh_status_vled_o (cl_sh_status_vled_o)
  );

  tb_link_model #(.SKEW(SKEW)) link_model_inst (
    .clk_main_a0      (clk_main_a0),
    .rst_main_n_sync  (rst_main_n_sync),
    .link_req_i       (link_req_o),
    .link_req_valid_i (link_req_valid_o),
    .link_req_ready_o (link_req_ready_i),
    .link_rsp_o       (link_rsp_i),
    .link_rsp_valid_o (link_rsp_valid_i)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  // Hold the request until ready is seen mid cycle
  task automatic issue_access(input case_t c);
    logic     accepted;
    expect_t  e;
    host_req_i.write = (c.op == OP_WRITE);
    host_req_i.addr  = c.addr;
    host_req_i.data  = c.data;
    host_req_i.strb  = c.strb;
    host_req_valid_i = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk_main_a0);
      accepted = host_req_ready_o;
      if (accepted) begin
        e.addr     = c.addr;
        e.data     = c.exp_data;
        e.resp     = c.exp_resp;
        e.led_read = (c.op == OP_READ) && !c.addr[31] &&
                     (c.addr[`CL_REG_IDX_W-1:0] == `CL_REG_VLED);
        exp_q.push_back(e);
      end
      @(posedge clk_main_a0);
      #SKEW;
    end
    host_req_valid_i = 1'b0;
  endtask

  task automatic set_dip(input logic [`CL_VIO_W-1:0] value);
    sh_cl_status_vdip_i = value;
    // Two synchronizer stages plus one spare edge
    repeat (3) @(posedge clk_main_a0);
    #SKEW;
  endtask

  task automatic drain_responses();
    while (exp_q.size() != 0) begin
      @(posedge clk_main_a0);
      #SKEW;
    end
  endtask

  //----------------------------------------------------------
  // Clock, response ready and cycle limit
  //----------------------------------------------------------
  initial begin
    clk_main_a0 = 1'b0;
    forever #(CLK_PERIOD / 2) clk_main_a0 = ~clk_main_a0;
  end

  initial begin
    host_rsp_ready_i = 1'b0;
    forever begin
      @(posedge clk_main_a0);
      #SKEW;
      host_rsp_ready_i = bp_mode ? ($urandom_range(1, 0) == 1) : 1'b1;
    end
  end

  initial begin
    forever begin
      @(posedge clk_main_a0);
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
        abort_run("Timeout: the run went past its cycle limit");
      end
    end
  end

  //----------------------------------------------------------
  // Response and link checks
  //----------------------------------------------------------
  always @(negedge clk_main_a0) begin
    expect_t e;
    if (rst_main_n_sync && host_rsp_valid_o && host_rsp_ready_i) begin
      assert (exp_q.size() != 0)
        else abort_run("A host response arrived with no request waiting for it");
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        assert (host_rsp_o.data == e.data && host_rsp_o.resp == e.resp)
          else abort_run($sformatf(
            "Error at time %0t: addr %h gave data %h resp %0d, expected %h resp %0d",
            $time, e.addr, host_rsp_o.data, host_rsp_o.resp, e.data, e.resp));
        if (e.led_read) begin
          assert (cl_sh_status_vled_o == e.data[`CL_VIO_W-1:0])
            else abort_run($sformatf("Error at time %0t: LED output %h, expected %h",
              $time, cl_sh_status_vled_o, e.data[`CL_VIO_W-1:0]));
        end
      end
    end
  end

  always @(negedge clk_main_a0) begin
    if (rst_main_n_sync) begin
      if (link_req_valid_o && link_req_ready_i) begin
        assert (link_unanswered < `CL_MAX_OUT_CREDITS)
          else abort_run("A link request went out with four requests unanswered");
        link_unanswered = link_unanswered + 1;
      end
      if (link_rsp_valid_i) begin
        link_unanswered = link_unanswered - 1;
      end
    end
  end

  //----------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------
  initial begin
    int           fd;
    int           n;
    string        line;
    logic [31:0]  f_op;
    logic [31:0]  f_addr;
    logic [31:0]  f_data;
    logic [31:0]  f_strb;
    logic [31:0]  f_exp_data;
    logic [31:0]  f_exp_resp;
    case_t        c;
    void'($urandom(SEED));
    rst_main_n_sync     = 1'b0;
    host_req_i          = '0;
    host_req_valid_i    = 1'b0;
    sh_cl_status_vdip_i = '0;
    bp_mode             = 1'b0;

    fd = $fopen("test/cl_host_cases.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the case file test/cl_host_cases.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h",
                    f_op, f_addr, f_data, f_strb, f_exp_data, f_exp_resp);
        if (n == 6) begin
          c.op       = f_op[3:0];
          c.addr     = f_addr;
          c.data     = f_data;
          c.strb     = f_strb[3:0];
          c.exp_data = f_exp_data;
          c.exp_resp = f_exp_resp[1:0];
          cases.push_back(c);
        end else if (n > 0) begin
          abort_run("A line of the case file does not hold six fields");
        end
      end
    end
    $fclose(fd);
    cycle_limit = RST_CYCLES + CYCLES_PER_CASE * cases.size();

    repeat (RST_CYCLES) @(posedge clk_main_a0);
    #SKEW;
    rst_main_n_sync = 1'b1;
    assert (!host_rsp_valid_o && !link_req_valid_o && cl_sh_status_vled_o == '0)
      else abort_run($sformatf("Error at time %0t: outputs not idle after reset", $time));

    foreach (cases[i]) begin
      case (cases[i].op)
        OP_READ, OP_WRITE: issue_access(cases[i]);
        OP_DIP:            set_dip(cases[i].data[`CL_VIO_W-1:0]);
        OP_DRAIN:          drain_responses();
        OP_BP:             bp_mode = cases[i].data[0];
        default:           abort_run("Unknown operation code in the case file");
      endcase
    end
    drain_responses();

    // Everything answered and nothing extra waiting at the host side
    if (link_unanswered == 0 && !host_rsp_valid_o) begin
      $display("Test passed");
      $finish;
    end else begin
      abort_run("The run ended with link requests or host responses still open");
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_link_model.sv ====
//----------------------------------------------------------
// Tile side link endpoint model
//----------------------------------------------------------
`default_nettype none

module tb_link_model
  import cl_host_pkg::*;
#(
  parameter int SKEW = 10
) (
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,

  input  link_req_t  link_req_i,
  input  logic       link_req_valid_i,
  output logic       link_req_ready_o,

  output link_rsp_t  link_rsp_o,
  output logic       link_rsp_valid_o
);

  typedef struct packed {
    logic [31:0]  data;
    logic [31:0]  due;
  } pending_t;

  // Word memory keyed by x, y and endpoint address
  logic [31:0]  mem [logic [27:0]];
  pending_t     pend_q [$];
  logic [31:0]  cycle_q;
  logic [31:0]  last_due;

  //----------------------------------------------------------
  // Request capture, sampled mid cycle
  //----------------------------------------------------------
  initial begin : accept_proc
    logic [27:0]  key;
    logic [31:0]  word;
    pending_t     ent;
    last_due = 32'h0;
    forever begin
      @(negedge clk_main_a0);
      if (rst_main_n_sync && link_req_valid_i && link_req_ready_o) begin
        key  = {link_req_i.x, link_req_i.y, link_req_i.epa};
        word = mem.exists(key) ? mem[key] : 32'h0;
        if (link_req_i.store) begin
          for (int b = 0; b < 4; b++) begin
            if (link_req_i.mask[b]) begin
              word[8*b +: 8] = link_req_i.data[8*b +: 8];
            end
          end
          mem[key] = word;
          ent.data = 32'h0;
        end else begin
          ent.data = word;
        end
        // Answer 1 to 3 cycles later, never ahead of an older answer
        ent.due = cycle_q + $urandom_range(3, 1);
        if (ent.due <= last_due) begin
          ent.due = last_due + 1;
        end
        last_due = ent.due;
        pend_q.push_back(ent);
      end
    end
  end

  //----------------------------------------------------------
  // Random ready and in-order responses
  //----------------------------------------------------------
  initial begin : drive_proc
    link_req_ready_o = 1'b0;
    link_rsp_valid_o = 1'b0;
    link_rsp_o       = '0;
    cycle_q          = 32'h0;
    forever begin
      @(posedge clk_main_a0);
      cycle_q = cycle_q + 1;
      #SKEW;
      link_req_ready_o = ($urandom_range(3, 0) != 0);
      if (pend_q.size() != 0 && pend_q[0].due <= cycle_q) begin
        link_rsp_o.data  = pend_q[0].data;
        link_rsp_valid_o = 1'b1;
        void'(pend_q.pop_front());
      end else begin
        link_rsp_o       = '0;
        link_rsp_valid_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire
